// File: src/dispatchControl.sv
`default_nettype none
`include "rename_macros.svh"

module dispatchControl (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 issueEn,
    input  wire                 flush,
    input  wire                 headDone,
    input  wire [`ROB_TAG_W:0]  count,
    output logic                issueReady,
    output logic                allocEn,
    output logic                commitEn,
    output logic                flushNow
);

    renamePkg::ctrlStateT state;
    renamePkg::ctrlStateT nextState;

    assign flushNow = (state == renamePkg::Flush);

    // An incoming flush strobe blocks issue and commit in the same cycle.
    assign issueReady = (state == renamePkg::Run) && (count != `ROB_DEPTH) && !flush;
    assign allocEn    = issueEn && issueReady;
    assign commitEn   = (count != '0) && headDone && !flushNow && !flush;

    always_comb begin
        nextState = state;
        case (state)
            renamePkg::Run: begin
                if (allocEn && !commitEn && (count == `ROB_DEPTH - 1)) begin
                    nextState = renamePkg::Full;
                end
            end
            renamePkg::Full: begin
                if (commitEn) begin
                    nextState = renamePkg::Run;
                end
            end
            default: nextState = renamePkg::Run;
        endcase
        if (flush) begin
            nextState = renamePkg::Flush;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= renamePkg::Run;
        end else begin
            state <= nextState;
        end
    end

endmodule

`default_nettype wire

// File: src/regFile.sv
`default_nettype none
`include "rename_macros.svh"

module regFile (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       allocEn,
    input  wire  [`ROB_TAG_W-1:0]     allocTag,
    input  wire  renamePkg::issueT    issue,
    input  wire                       commitEn,
    input  wire  renamePkg::commitT   commit,
    input  wire                       flushNow,
    output logic                      dispatchEn,
    output renamePkg::dispatchT       dispatch
);

    logic [`DATA_W-1:0]    regValue [`REG_NUM];
    logic [`ROB_TAG_W-1:0] regTag   [`REG_NUM];
    logic [`REG_NUM-1:0]   regBusy;

    logic               commitWrite;
    logic               renameWrite;
    renamePkg::operandT rs1Read;
    renamePkg::operandT rs2Read;

    // x0 is hardwired, so it is neither written nor renamed.
    assign commitWrite = commitEn && commit.writesRd && (commit.rd != '0);
    assign renameWrite = allocEn && issue.writesRd && (issue.rd != '0);

    // Reads see a commit landing in the same cycle. The busy bit only drops
    // if the committing tag is still the one recorded for the register.
    function automatic renamePkg::operandT readOperand(
        input logic [`REG_IDX_W-1:0] idx
    );
        renamePkg::operandT op;
        op.value = regValue[idx];
        op.busy  = regBusy[idx];
        op.tag   = regTag[idx];
        if (commitWrite && (commit.rd == idx)) begin
            op.value = commit.data;
            if (regTag[idx] == commit.tag) begin
                op.busy = 1'b0;
            end
        end
        return op;
    endfunction

    always_comb begin
        rs1Read = readOperand(issue.rs1);
        rs2Read = readOperand(issue.rs2);
    end

    // A rename in the same cycle as a commit to the same register must win,
    // so it is assigned after the commit update. Flush overrides both.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regValue[i] <= '0;
                regTag[i]   <= '0;
            end
            regBusy <= '0;
        end else begin
            if (commitWrite) begin
                regValue[commit.rd] <= commit.data;
                if (regTag[commit.rd] == commit.tag) begin
                    regBusy[commit.rd] <= 1'b0;
                end
            end
            if (renameWrite) begin
                regBusy[issue.rd] <= 1'b1;
                regTag[issue.rd]  <= allocTag;
            end
            if (flushNow) begin
                regBusy <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatchEn <= 1'b0;
        end else begin
            dispatchEn <= allocEn;
        end
    end

    always_ff @(posedge clk) begin
        if (allocEn) begin
            dispatch.opcode   <= issue.opcode;
            dispatch.pc       <= issue.pc;
            dispatch.imm      <= issue.imm;
            dispatch.rd       <= issue.rd;
            dispatch.writesRd <= issue.writesRd;
            dispatch.tag      <= allocTag;
            dispatch.rs1      <= rs1Read;
            dispatch.rs2      <= rs2Read;
        end
    end

endmodule

`default_nettype wire

// File: src/renamePkg.sv
`default_nettype none
`include "rename_macros.svh"

package renamePkg;

    // Decoded instruction as it comes in for rename.
    typedef struct packed {
        logic [6:0]            opcode;
        logic [31:0]           pc;
        logic [31:0]           imm;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rd;
        logic                  writesRd;
    } issueT;

    // When busy is set the value is stale and tag names the producer.
    typedef struct packed {
        logic                  busy;
        logic [`ROB_TAG_W-1:0] tag;
        logic [`DATA_W-1:0]    value;
    } operandT;

    typedef struct packed {
        logic [6:0]            opcode;
        logic [31:0]           pc;
        logic [31:0]           imm;
        logic [`REG_IDX_W-1:0] rd;
        logic                  writesRd;
        logic [`ROB_TAG_W-1:0] tag;
        operandT               rs1;
        operandT               rs2;
    } dispatchT;

    typedef struct packed {
        logic [`ROB_TAG_W-1:0] tag;
        logic [`DATA_W-1:0]    data;
    } writebackT;

    typedef struct packed {
        logic [`REG_IDX_W-1:0] rd;
        logic                  writesRd;
        logic [`ROB_TAG_W-1:0] tag;
        logic [`DATA_W-1:0]    data;
    } commitT;

    typedef enum logic [1:0] {
        Run,
        Full,
        Flush
    } ctrlStateT;

endpackage

`default_nettype wire

// File: src/renameTop.sv
`default_nettype none
`include "rename_macros.svh"

module renameTop (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          issueEn,
    input  wire  renamePkg::issueT       issue,
    output logic                         issueReady,
    output logic                         dispatchEn,
    output renamePkg::dispatchT          dispatch,
    input  wire                          wbEn,
    input  wire  renamePkg::writebackT   wb,
    output logic                         commitEn,
    output renamePkg::commitT            commit,
    input  wire                          flush
);

    logic                  allocEn;
    logic                  flushNow;
    logic                  headDone;
    logic [`ROB_TAG_W-1:0] tailIdx;
    logic [`ROB_TAG_W-1:0] headIdx;
    logic [`ROB_TAG_W:0]   count;

    dispatchControl control (
        .clk        (clk),
        .rst        (rst),
        .issueEn    (issueEn),
        .flush      (flush),
        .headDone   (headDone),
        .count      (count),
        .issueReady (issueReady),
        .allocEn    (allocEn),
        .commitEn   (commitEn),
        .flushNow   (flushNow)
    );

    robPointers pointers (
        .clk      (clk),
        .rst      (rst),
        .allocEn  (allocEn),
        .commitEn (commitEn),
        .flushNow (flushNow),
        .tailIdx  (tailIdx),
        .headIdx  (headIdx),
        .count    (count)
    );

    // The head entry doubles as the commit payload.
    robBuffer rob (
        .clk       (clk),
        .allocEn   (allocEn),
        .tailIdx   (tailIdx),
        .issue     (issue),
        .wbEn      (wbEn),
        .wb        (wb),
        .headIdx   (headIdx),
        .headDone  (headDone),
        .headEntry (commit),
        .flushNow  (flushNow)
    );

    regFile regs (
        .clk        (clk),
        .rst        (rst),
        .allocEn    (allocEn),
        .allocTag   (tailIdx),
        .issue      (issue),
        .commitEn   (commitEn),
        .commit     (commit),
        .flushNow   (flushNow),
        .dispatchEn (dispatchEn),
        .dispatch   (dispatch)
    );

endmodule

`default_nettype wire

// File: src/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Architectural register file geometry.
`define REG_NUM     32
`define REG_IDX_W   5

// Width of one data word.
`define DATA_W      32

// Reorder buffer geometry. A tag is the entry index.
`define ROB_DEPTH   8
`define ROB_TAG_W   3

`endif

// File: src/robBuffer.sv
`default_nettype none
`include "rename_macros.svh"

module robBuffer (
    input  wire                          clk,
    input  wire                          allocEn,
    input  wire  [`ROB_TAG_W-1:0]        tailIdx,
    input  wire  renamePkg::issueT       issue,
    input  wire                          wbEn,
    input  wire  renamePkg::writebackT   wb,
    input  wire  [`ROB_TAG_W-1:0]        headIdx,
    output logic                         headDone,
    output renamePkg::commitT            headEntry,
    input  wire                          flushNow
);

    logic [`REG_IDX_W-1:0] entryRd [`ROB_DEPTH];
    logic [`DATA_W-1:0]    entryData [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] entryWritesRd;
    logic [`ROB_DEPTH-1:0] entryDone;

    // Destination info is captured at allocation time.
    always_ff @(posedge clk) begin
        if (allocEn) begin
            entryRd[tailIdx]       <= issue.rd;
            entryWritesRd[tailIdx] <= issue.writesRd;
        end
    end

    always_ff @(posedge clk) begin
        if (wbEn) begin
            entryData[wb.tag] <= wb.data;
        end
    end

    // A writeback always targets an in-flight entry, never the one being
    // allocated, so the two updates touch different bits.
    always_ff @(posedge clk) begin
        if (flushNow) begin
            entryDone <= '0;
        end else begin
            if (allocEn) begin
                entryDone[tailIdx] <= 1'b0;
            end
            if (wbEn) begin
                entryDone[wb.tag] <= 1'b1;
            end
        end
    end

    always_comb begin
        headDone           = entryDone[headIdx];
        headEntry.rd       = entryRd[headIdx];
        headEntry.writesRd = entryWritesRd[headIdx];
        headEntry.tag      = headIdx;
        headEntry.data     = entryData[headIdx];
    end

endmodule

`default_nettype wire

// File: src/robPointers.sv
`default_nettype none
`include "rename_macros.svh"

module robPointers (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   allocEn,
    input  wire                   commitEn,
    input  wire                   flushNow,
    output logic [`ROB_TAG_W-1:0] tailIdx,
    output logic [`ROB_TAG_W-1:0] headIdx,
    output logic [`ROB_TAG_W:0]   count
);

    // Depth is a power of two, so both pointers wrap on overflow.
    always_ff @(posedge clk) begin
        if (rst || flushNow) begin
            tailIdx <= '0;
            headIdx <= '0;
            count   <= '0;
        end else begin
            if (allocEn) begin
                tailIdx <= tailIdx + 1'b1;
            end
            if (commitEn) begin
                headIdx <= headIdx + 1'b1;
            end
            // Allocate and commit in one cycle leave the count unchanged.
            case ({allocEn, commitEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verification/renameTb.sv
`default_nettype none
`include "rename_macros.svh"

module renameTb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                 clk;
    logic                 rst;
    logic                 issueEn;
    renamePkg::issueT     issue;
    logic                 issueReady;
    logic                 dispatchEn;
    renamePkg::dispatchT  dispatch;
    logic                 wbEn;
    renamePkg::writebackT wb;
    logic                 commitEn;
    renamePkg::commitT    commit;
    logic                 flush;

    // Reference model. Buffer entries are indexed by their tag.
    logic [`DATA_W-1:0]    regVal [`REG_NUM];
    logic [`ROB_TAG_W-1:0] regTag [`REG_NUM];
    logic                  regBusy [`REG_NUM];
    logic [`REG_IDX_W-1:0] robRd [`ROB_DEPTH];
    logic                  robWritesRd [`ROB_DEPTH];
    logic                  robDone [`ROB_DEPTH];
    logic [`DATA_W-1:0]    robData [`ROB_DEPTH];
    int                    head;
    int                    tail;
    int                    inFlight;
    logic                  flushing;
    logic                  expDispatchEn;
    renamePkg::dispatchT   expDispatch;
    string                 testName;

    tbClock clock (.clk(clk));

    renameTop dut (.*);

    task automatic stopRun();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic checkFlag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: %s expected %b actual %b", testName, what, exp, act);
            stopRun();
        end
    endtask

    task automatic checkDispatch(input renamePkg::dispatchT exp,
                                 input renamePkg::dispatchT act);
        if (act !== exp) begin
            $display("ERROR %s: dispatch expected %h actual %h", testName, exp, act);
            stopRun();
        end
    endtask

    task automatic checkCommit(input renamePkg::commitT exp, input renamePkg::commitT act);
        if (act !== exp) begin
            $display("ERROR %s: commit expected %h actual %h", testName, exp, act);
            stopRun();
        end
    endtask

    // Flush keeps values and tags while reset clears everything.
    task automatic resetModel(input logic keepValues);
        for (int i = 0; i < `REG_NUM; i++) begin
            regBusy[i] = 1'b0;
            if (!keepValues) begin
                regVal[i] = '0;
                regTag[i] = '0;
            end
        end
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            robDone[i] = 1'b0;
        end
        head     = 0;
        tail     = 0;
        inFlight = 0;
    endtask

    // Registers x0 to x7 only, so that renames collide often.
    function automatic logic [`REG_IDX_W-1:0] smallReg();
        logic [31:0] r;
        r = $urandom_range(0, 7);
        return r[`REG_IDX_W-1:0];
    endfunction

    function automatic renamePkg::issueT randomIssue(input logic noDest);
        renamePkg::issueT ins;
        logic [31:0]      r;
        r            = $urandom;
        ins.opcode   = r[6:0];
        ins.pc       = $urandom;
        ins.imm      = $urandom;
        ins.rs1      = smallReg();
        ins.rs2      = smallReg();
        ins.rd       = smallReg();
        r            = $urandom_range(0, 3);
        ins.writesRd = (r != 0);
        if (noDest && r[0]) begin
            ins.writesRd = 1'b0;
        end else if (noDest) begin
            ins.rd = '0;
        end
        return ins;
    endfunction

    // Each call covers one clock cycle. It checks the last dispatch, drives inputs,
    // checks the combinational outputs, then advances the model as the rising edge will.
    task automatic stepCycle(input int issuePct, input int wbPct, input logic flushReq,
                             input logic noDest);
        logic              ready;
        logic              doCommit;
        int                pick;
        renamePkg::commitT expCommit;
        @(negedge clk);
        checkFlag("dispatchEn", expDispatchEn, dispatchEn);
        if (expDispatchEn) begin
            checkDispatch(expDispatch, dispatch);
        end
        flush   = flushReq;
        issueEn = ($urandom_range(0, 99) < issuePct);
        issue   = randomIssue(noDest);
        wbEn    = 1'b0;
        wb      = '0;
        if (!flushReq && !flushing && inFlight > 0 && $urandom_range(0, 99) < wbPct) begin
            pick = (head + $urandom_range(0, inFlight - 1)) % `ROB_DEPTH;
            if (!robDone[pick]) begin
                wbEn    = 1'b1;
                wb.tag  = pick[`ROB_TAG_W-1:0];
                wb.data = $urandom;
            end
        end
        #1;
        ready    = !flushing && !flushReq && (inFlight != `ROB_DEPTH);
        doCommit = !flushing && !flushReq && (inFlight != 0) && robDone[head];
        checkFlag("issueReady", ready, issueReady);
        checkFlag("commitEn", doCommit, commitEn);
        if (doCommit) begin
            expCommit = {robRd[head], robWritesRd[head], head[`ROB_TAG_W-1:0], robData[head]};
            checkCommit(expCommit, commit);
            if (robWritesRd[head] && robRd[head] != '0) begin
                regVal[robRd[head]] = robData[head];
                if (regTag[robRd[head]] == head[`ROB_TAG_W-1:0]) begin
                    regBusy[robRd[head]] = 1'b0;
                end
            end
            head = (head + 1) % `ROB_DEPTH;
            inFlight--;
        end
        // Operands are read after the commit above and before the rename below.
        expDispatchEn = issueEn && ready;
        if (expDispatchEn) begin
            expDispatch = {issue.opcode, issue.pc, issue.imm, issue.rd, issue.writesRd,
                           tail[`ROB_TAG_W-1:0],
                           regBusy[issue.rs1], regTag[issue.rs1], regVal[issue.rs1],
                           regBusy[issue.rs2], regTag[issue.rs2], regVal[issue.rs2]};
            robRd[tail]       = issue.rd;
            robWritesRd[tail] = issue.writesRd;
            robDone[tail]     = 1'b0;
            if (issue.writesRd && issue.rd != '0) begin
                regBusy[issue.rd] = 1'b1;
                regTag[issue.rd]  = tail[`ROB_TAG_W-1:0];
            end
            tail = (tail + 1) % `ROB_DEPTH;
            inFlight++;
        end
        if (wbEn) begin
            robDone[wb.tag] = 1'b1;
            robData[wb.tag] = wb.data;
        end
        if (flushing) begin
            resetModel(1'b1);
        end
        flushing = flushReq;
    endtask

    task automatic runRandom(input int cycles, input int issuePct, input int wbPct,
                             input int flushPct, input logic noDest);
        for (int i = 0; i < cycles; i++) begin
            stepCycle(issuePct, wbPct, $urandom_range(0, 99) < flushPct, noDest);
        end
    endtask

    task automatic drainBuffer();
        int waited;
        waited = 0;
        while (inFlight != 0 && waited < 200) begin
            stepCycle(0, 100, 1'b0, 1'b0);
            waited++;
        end
        if (inFlight != 0) begin
            $display("Reorder buffer did not drain within 200 cycles in test %s.", testName);
            stopRun();
        end
    endtask

    initial begin
        int waited;
        void'($urandom(69));
        rst           = 1'b1;
        flush         = 1'b0;
        issueEn       = 1'b0;
        issue         = '0;
        wbEn          = 1'b0;
        wb            = '0;
        expDispatchEn = 1'b0;
        flushing      = 1'b0;
        resetModel(1'b0);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        testName = "resetFirstDispatch";
        stepCycle(100, 0, 1'b0, 1'b0);
        stepCycle(0, 0, 1'b0, 1'b0);

        testName = "renameRead";
        runRandom(400, 60, 30, 0, 1'b0);
        drainBuffer();

        testName = "inOrderCommit";
        runRandom(1500, 80, 50, 0, 1'b0);
        drainBuffer();

        testName = "fullStall";
        runRandom(12, 100, 0, 0, 1'b0);
        waited = 0;
        do begin
            stepCycle(0, 100, 1'b0, 1'b0);
            waited++;
        end while (!issueReady && waited < 50);
        if (!issueReady) begin
            $display("issueReady did not return within 50 cycles of writebacks.");
            stopRun();
        end
        drainBuffer();

        testName = "flush";
        runRandom(600, 70, 40, 4, 1'b0);
        drainBuffer();

        testName = "noDestination";
        runRandom(400, 70, 50, 0, 1'b1);
        drainBuffer();
        stepCycle(0, 0, 1'b0, 1'b0);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tbClock.sv
`default_nettype none

module tbClock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // Free running clock with an 8 ns period.
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/renamePkg.sv
src/regFile.sv
src/robBuffer.sv
src/robPointers.sv
src/dispatchControl.sv
src/renameTop.sv
verification/tbClock.sv
verification/renameTb.sv
